//--- biphase_to_nrz.sv
`timescale 1ns/100ps

module biphase_to_nrz (
  input  logic                     clk,
  input  logic                     rs,
  input  logic                     symb_clk_en,
  input  logic                     symb,
  input  logic                     biphase,
  input  pcm_code_pkg::line_code_e code,
  output pcm_code_pkg::bit_s       nrz
);

  logic       phase;       // high while waiting for the second half
  logic       first_half;
  logic [2:0] cfg_q;
  logic       cfg_chg;
  logic       pair_bit;

  // A new mode restarts the half-bit pairing
  assign cfg_chg = (cfg_q != {biphase, code});

  always_comb begin
    case (code)
      pcm_code_pkg::code_m: pair_bit = first_half ^ symb;
      pcm_code_pkg::code_s: pair_bit = ~(first_half ^ symb);
      default:              pair_bit = first_half;
    endcase
  end

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      phase <= 1'b0;
      cfg_q <= '0;
      nrz   <= '0;
    end else begin
      cfg_q   <= {biphase, code};
      nrz.stb <= 1'b0;
      if (!biphase) begin
        phase <= 1'b0;
        if (symb_clk_en) begin
          nrz.stb     <= 1'b1;
          nrz.bit_val <= symb;
        end
      end else if (symb_clk_en) begin
        if (phase && !cfg_chg) begin
          phase       <= 1'b0;
          nrz.stb     <= 1'b1;
          nrz.bit_val <= pair_bit;
        end else begin
          phase <= 1'b1;
        end
      end else if (cfg_chg) begin
        phase <= 1'b0;
      end
    end
  end

  // First half sample
  always_ff @(posedge clk) begin
    if (biphase && symb_clk_en && (!phase || cfg_chg)) begin
      first_half <= symb;
    end
  end

  a_stb_single: assert property (
    @(posedge clk) disable iff (rs)
    nrz.stb |=> !nrz.stb
  );

endmodule

//--- decoder_regs.sv
`timescale 1ns/100ps

module decoder_regs (
  input  logic                   clk,
  input  logic                   rs,
  input  pcm_regs_pkg::bus_req_s bus,
  output logic [31:0]            rdata,
  output pcm_regs_pkg::dec_cfg_s cfg
);

  logic [31:0] ctrl;
  logic        addr_hit;
  logic        wr_en;

  assign addr_hit = (bus.addr == pcm_regs_pkg::addr_ctrl);
  assign wr_en    = bus.cs && addr_hit && (|bus.be);

  // ----------------------------------------------------------
  // Control register with byte lane writes
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      ctrl <= '0;
    end else if (wr_en) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.be[i]) begin
          ctrl[8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  // Readback is combinational
  assign rdata = addr_hit ? ctrl : 32'h0;

  // ----------------------------------------------------------
  // Field decode
  // ----------------------------------------------------------
  assign cfg.code = pcm_code_pkg::line_code_e'(
    ctrl[pcm_regs_pkg::code_lsb +: pcm_regs_pkg::code_w]);
  assign cfg.biphase = ctrl[pcm_regs_pkg::biphase_bit];
  assign cfg.derand = pcm_code_pkg::derand_e'(
    ctrl[pcm_regs_pkg::derand_lsb +: pcm_regs_pkg::derand_w]);
  assign cfg.data_inv   = ctrl[pcm_regs_pkg::data_inv_bit];
  assign cfg.clk_sel    = ctrl[pcm_regs_pkg::clk_sel_bit];
  assign cfg.clk_phase  = ctrl[pcm_regs_pkg::clk_phase_lsb +: pcm_regs_pkg::clk_phase_w];
  assign cfg.fifo_reset = ctrl[pcm_regs_pkg::fifo_reset_bit];

  // No change to the register without an addressed, strobed write
  a_ctrl_stable: assert property (
    @(posedge clk) disable iff (rs)
    !wr_en |=> $stable(ctrl)
  );

endmodule

//--- mark_space_decode.sv
`timescale 1ns/100ps

module mark_space_decode (
  input  logic                     clk,
  input  logic                     rs,
  input  logic                     biphase,
  input  pcm_code_pkg::line_code_e code,
  input  pcm_code_pkg::bit_s       din,
  output pcm_code_pkg::bit_s       dout
);

  logic prev_lvl;
  logic dec_bit;

  // Biphase bits are already level coded
  always_comb begin
    if (biphase) begin
      dec_bit = din.bit_val;
    end else begin
      case (code)
        pcm_code_pkg::code_m: dec_bit = din.bit_val ^ prev_lvl;
        pcm_code_pkg::code_s: dec_bit = ~(din.bit_val ^ prev_lvl);
        default:              dec_bit = din.bit_val;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      prev_lvl <= 1'b0;
      dout     <= '0;
    end else begin
      dout.stb <= din.stb;
      if (din.stb) begin
        prev_lvl     <= din.bit_val;
        dout.bit_val <= dec_bit;
      end
    end
  end

endmodule

//--- nrz_derandomizer.sv
`timescale 1ns/100ps

module nrz_derandomizer (
  input  logic                  clk,
  input  logic                  rs,
  input  pcm_code_pkg::derand_e derand,
  input  logic                  data_inv,
  input  pcm_code_pkg::bit_s    din,
  output pcm_code_pkg::bit_s    dout
);

  logic [pcm_code_pkg::hist_len-1:0] hist;
  logic                              tap_a;
  logic                              tap_b;
  logic                              plain;

  // ----------------------------------------------------------
  // Tap selection from history before the shift
  // ----------------------------------------------------------
  always_comb begin
    case (derand)
      pcm_code_pkg::rnrz9: begin
        tap_a = hist[pcm_code_pkg::tap_rnrz9_a - 1];
        tap_b = hist[pcm_code_pkg::tap_rnrz9_b - 1];
      end
      pcm_code_pkg::rnrz11: begin
        tap_a = hist[pcm_code_pkg::tap_rnrz11_a - 1];
        tap_b = hist[pcm_code_pkg::tap_rnrz11_b - 1];
      end
      pcm_code_pkg::rnrz17: begin
        tap_a = hist[pcm_code_pkg::tap_rnrz17_a - 1];
        tap_b = hist[pcm_code_pkg::tap_rnrz17_b - 1];
      end
      pcm_code_pkg::rnrz23: begin
        tap_a = hist[pcm_code_pkg::tap_rnrz23_a - 1];
        tap_b = hist[pcm_code_pkg::tap_rnrz23_b - 1];
      end
      // rnrz15 and the unused codes
      default: begin
        tap_a = hist[pcm_code_pkg::tap_rnrz15_a - 1];
        tap_b = hist[pcm_code_pkg::tap_rnrz15_b - 1];
      end
    endcase
  end

  assign plain = (derand == pcm_code_pkg::derand_off) ? din.bit_val :
                 (din.bit_val ^ tap_a ^ tap_b);

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      hist <= '0;
      dout <= '0;
    end else begin
      dout.stb <= din.stb;
      if (din.stb) begin
        hist         <= {hist[pcm_code_pkg::hist_len-2:0], din.bit_val};
        dout.bit_val <= plain ^ data_inv;
      end
    end
  end

  a_stb_follow: assert property (
    @(posedge clk) disable iff (rs)
    1'b1 |=> (dout.stb == $past(din.stb))
  );

endmodule

//--- pcm_code_pkg.sv
package pcm_code_pkg;

  // ----------------------------------------------------------
  // Line code and derandomizer selections
  // ----------------------------------------------------------

  // Line code within the NRZ or biphase family
  typedef enum logic [1:0] {
    code_l = 2'd0,
    code_m = 2'd1,
    code_s = 2'd2
  } line_code_e;

  // Derandomizer polynomial select
  // Unused codes 6 and 7 decode as rnrz15
  typedef enum logic [2:0] {
    derand_off = 3'd0,
    rnrz9      = 3'd1,
    rnrz11     = 3'd2,
    rnrz15     = 3'd3,
    rnrz17     = 3'd4,
    rnrz23     = 3'd5
  } derand_e;

  // Enough history for the longest polynomial
  localparam int hist_len = 23;

  // Tap positions counted from 1 at the newest history bit
  localparam int tap_rnrz9_a  = 9;
  localparam int tap_rnrz9_b  = 5;
  localparam int tap_rnrz11_a = 11;
  localparam int tap_rnrz11_b = 9;
  localparam int tap_rnrz15_a = 15;
  localparam int tap_rnrz15_b = 14;
  localparam int tap_rnrz17_a = 17;
  localparam int tap_rnrz17_b = 14;
  localparam int tap_rnrz23_a = 23;
  localparam int tap_rnrz23_b = 18;

  // Link between decode stages
  typedef struct packed {
    logic stb;
    logic bit_val;
  } bit_s;

endpackage

//--- pcm_decoder.sv
`timescale 1ns/100ps

module pcm_decoder (
  input  logic                   clk,
  input  logic                   rs,
  input  pcm_regs_pkg::bus_req_s bus,
  output logic [31:0]            rdata,
  input  logic                   symb_clk_en,
  input  logic                   symb_clk_2x_en,
  input  logic                   symb,
  output logic                   data_out,
  output logic                   clk_en_out,
  output logic                   symb_clk,
  output logic                   fifo_rs,
  output logic [1:0]             clk_phase
);

  pcm_regs_pkg::dec_cfg_s cfg;
  pcm_code_pkg::bit_s     nrz_bit;
  pcm_code_pkg::bit_s     lvl_bit;
  pcm_code_pkg::bit_s     out_bit;

  decoder_regs u_regs (
    .clk   (clk),
    .rs    (rs),
    .bus   (bus),
    .rdata (rdata),
    .cfg   (cfg)
  );

  assign fifo_rs   = cfg.fifo_reset;
  assign clk_phase = cfg.clk_phase;

  // ----------------------------------------------------------
  // Decode chain
  // ----------------------------------------------------------
  biphase_to_nrz u_biphase (
    .clk         (clk),
    .rs          (rs),
    .symb_clk_en (symb_clk_en),
    .symb        (symb),
    .biphase     (cfg.biphase),
    .code        (cfg.code),
    .nrz         (nrz_bit)
  );

  mark_space_decode u_mark_space (
    .clk     (clk),
    .rs      (rs),
    .biphase (cfg.biphase),
    .code    (cfg.code),
    .din     (nrz_bit),
    .dout    (lvl_bit)
  );

  nrz_derandomizer u_derand (
    .clk      (clk),
    .rs       (rs),
    .derand   (cfg.derand),
    .data_inv (cfg.data_inv),
    .din      (lvl_bit),
    .dout     (out_bit)
  );

  // Output clocking
  symbol_clock_gen u_clk_gen (
    .clk            (clk),
    .rs             (rs),
    .bit_in         (out_bit),
    .symb_clk_en    (symb_clk_en),
    .symb_clk_2x_en (symb_clk_2x_en),
    .biphase        (cfg.biphase),
    .clk_sel        (cfg.clk_sel),
    .data_out       (data_out),
    .clk_en_out     (clk_en_out),
    .symb_clk       (symb_clk)
  );

endmodule

//--- pcm_regs_pkg.sv
package pcm_regs_pkg;

  localparam int addr_w = 13;
  localparam logic [addr_w-1:0] addr_ctrl = 13'h0000;

  // ----------------------------------------------------------
  // Control register field positions
  // ----------------------------------------------------------
  localparam int code_lsb       = 0;
  localparam int code_w         = 2;
  localparam int biphase_bit    = 2;
  localparam int derand_lsb     = 4;
  localparam int derand_w       = 3;
  localparam int data_inv_bit   = 8;
  localparam int clk_sel_bit    = 9;
  localparam int clk_phase_lsb  = 16;
  localparam int clk_phase_w    = 2;
  localparam int fifo_reset_bit = 24;

  // Register bus request from the host side
  typedef struct packed {
    logic              cs;
    logic [3:0]        be;
    logic [addr_w-1:0] addr;
    logic [31:0]       wdata;
  } bus_req_s;

  // Decoded configuration for the decode chain and top outputs
  typedef struct packed {
    pcm_code_pkg::line_code_e code;
    logic                     biphase;
    pcm_code_pkg::derand_e    derand;
    logic                     data_inv;
    logic                     clk_sel;
    logic [clk_phase_w-1:0]   clk_phase;
    logic                     fifo_reset;
  } dec_cfg_s;

endpackage

//--- symbol_clock_gen.sv
`timescale 1ns/100ps

module symbol_clock_gen (
  input  logic               clk,
  input  logic               rs,
  input  pcm_code_pkg::bit_s bit_in,
  input  logic               symb_clk_en,
  input  logic               symb_clk_2x_en,
  input  logic               biphase,
  input  logic               clk_sel,
  output logic               data_out,
  output logic               clk_en_out,
  output logic               symb_clk
);

  // Three stages match the depth of the decode chain
  logic [2:0] en_dly;
  logic [2:0] x2_dly;
  logic       half_stb;
  logic       clk_q;
  logic       clk_nxt;

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      en_dly <= '0;
      x2_dly <= '0;
      clk_q  <= 1'b0;
    end else begin
      en_dly <= {en_dly[1:0], symb_clk_en};
      x2_dly <= {x2_dly[1:0], symb_clk_2x_en};
      clk_q  <= clk_nxt;
    end
  end

  assign half_stb = biphase ? en_dly[2] : x2_dly[2];

  // High on a bit, toggle on the other half strobes
  always_comb begin
    clk_nxt = clk_q;
    if (bit_in.stb) begin
      clk_nxt = 1'b1;
    end else if (half_stb) begin
      clk_nxt = ~clk_q;
    end
  end

  assign data_out   = bit_in.bit_val;
  assign clk_en_out = clk_sel ? bit_in.stb : x2_dly[2];
  // Next state drives the pin so the clock is high with clk_en_out
  assign symb_clk   = clk_sel ? clk_nxt : x2_dly[2];

endmodule

//--- tb.f
pcm_code_pkg.sv
pcm_regs_pkg.sv
decoder_regs.sv
biphase_to_nrz.sv
mark_space_decode.sv
nrz_derandomizer.sv
symbol_clock_gen.sv
pcm_decoder.sv
tb_pcm_decoder.sv

//--- tb_pcm_decoder.sv
`timescale 1ns/100ps

module tb_pcm_decoder;

  logic                   clk;
  logic                   rs;
  pcm_regs_pkg::bus_req_s bus;
  logic [31:0]            rdata;
  logic                   symb_clk_en;
  logic                   symb_clk_2x_en;
  logic                   symb;
  logic                   data_out;
  logic                   clk_en_out;
  logic                   symb_clk;
  logic                   fifo_rs;
  logic [1:0]             clk_phase;

  integer     seed;
  int         errors;
  int         checks;
  int         cycle;
  int         first_cyc;   // edge that sampled the first queued symbol
  int         first_out;   // edge that saw the first collected bit
  int         clk_errs;
  logic       collect;
  logic       from_q;
  logic [1:0] ph;
  bit         sym_q[$];
  bit         tx_buf[$];
  bit         exp_q[$];
  bit         rx_q[$];

  pcm_decoder uut (
    .clk            (clk),
    .rs             (rs),
    .bus            (bus),
    .rdata          (rdata),
    .symb_clk_en    (symb_clk_en),
    .symb_clk_2x_en (symb_clk_2x_en),
    .symb           (symb),
    .data_out       (data_out),
    .clk_en_out     (clk_en_out),
    .symb_clk       (symb_clk),
    .fifo_rs        (fifo_rs),
    .clk_phase      (clk_phase)
  );

  always #20 clk = ~clk;

  // ----------------------------------------------------------
  // Strobe and symbol source, symbol strobe every 4 clocks
  // ----------------------------------------------------------
  always @(posedge clk) begin
    ph             <= ph + 2'd1;
    symb_clk_2x_en <= ph[0];
    symb_clk_en    <= (ph == 2'd3);
    if (ph == 2'd3) begin
      if (sym_q.size() > 0) begin
        symb   <= sym_q.pop_front();
        from_q <= 1'b1;
      end else begin
        symb   <= 1'b0;
        from_q <= 1'b0;
      end
    end
  end

  // Output collector
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (symb_clk_en && from_q && first_cyc < 0) begin
      first_cyc = cycle;
    end
    if (collect && clk_en_out && first_cyc >= 0 && cycle >= first_cyc + 3) begin
      if (rx_q.size() == 0) begin
        first_out = cycle;
      end
      rx_q.push_back(data_out);
      if (!symb_clk) begin
        clk_errs = clk_errs + 1;
      end
    end
  end

  function automatic bit rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[7];
  endfunction

  function automatic logic [31:0] cfg_word(input logic [1:0] code, input logic biphase,
                                           input logic [2:0] derand, input logic inv,
                                           input logic sel);
    logic [31:0] w;
    w = '0;
    w[pcm_regs_pkg::code_lsb +: pcm_regs_pkg::code_w]     = code;
    w[pcm_regs_pkg::biphase_bit]                          = biphase;
    w[pcm_regs_pkg::derand_lsb +: pcm_regs_pkg::derand_w] = derand;
    w[pcm_regs_pkg::data_inv_bit]                         = inv;
    w[pcm_regs_pkg::clk_sel_bit]                          = sel;
    return w;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic reset_dut;
    sym_q.delete();
    collect = 1'b0;
    @(posedge clk);
    rs  <= 1'b1;
    bus <= '0;
    repeat (16) @(posedge clk);
    rs <= 1'b0;
    rx_q.delete();
    first_cyc = -1;
    first_out = -1;
    clk_errs  = 0;
  endtask

  task automatic wait_symb_strobe;
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < 20 && !seen; n++) begin
      @(posedge clk);
      seen = symb_clk_en;
    end
    if (!seen) begin
      errors++;
      $display("Timed out waiting for symb_clk_en");
    end
  endtask

  task automatic bus_write(input logic sel, input logic [3:0] be,
                           input logic [12:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    bus.cs    <= sel;
    bus.be    <= be;
    bus.addr  <= addr;
    bus.wdata <= wdata;
    @(posedge clk);
    bus <= '0;
  endtask

  task automatic bus_read(input logic [12:0] addr, output logic [31:0] data);
    @(posedge clk);
    bus.cs   <= 1'b0;
    bus.be   <= 4'h0;
    bus.addr <= addr;
    @(posedge clk);
    data = rdata;
  endtask

  // ----------------------------------------------------------
  // Configure right after a symbol strobe, then send tx_buf
  // ----------------------------------------------------------
  task automatic run_and_check(input string name, input logic [31:0] word);
    bit got_all;
    reset_dut;
    wait_symb_strobe;
    bus_write(1'b1, 4'hf, pcm_regs_pkg::addr_ctrl, word);
    foreach (tx_buf[i]) sym_q.push_back(tx_buf[i]);
    collect = 1'b1;
    got_all = 1'b0;
    for (int n = 0; n < 20 * tx_buf.size() + 100 && !got_all; n++) begin
      @(posedge clk);
      got_all = (rx_q.size() >= exp_q.size());
    end
    collect = 1'b0;
    if (!got_all) begin
      errors++;
      $display("%s: timed out, only %0d of %0d bits came out", name, rx_q.size(),
               exp_q.size());
    end else begin
      foreach (exp_q[i]) check_val({name, " data_out"}, rx_q[i], exp_q[i]);
    end
    if (clk_errs != 0) begin
      errors++;
      $display("%s: symb_clk was low while clk_en_out was high", name);
    end
  endtask

  task automatic nrz_case(input logic [1:0] code, input string name);
    bit s;
    bit prev;
    tx_buf.delete();
    exp_q.delete();
    prev = 1'b0;
    for (int i = 0; i < 40; i++) begin
      s = rand_bit();
      tx_buf.push_back(s);
      if (code == pcm_code_pkg::code_m)
        exp_q.push_back(s ^ prev);
      else if (code == pcm_code_pkg::code_s)
        exp_q.push_back(~(s ^ prev));
      else
        exp_q.push_back(s);
      prev = s;
    end
    run_and_check(name, cfg_word(code, 1'b0, pcm_code_pkg::derand_off, 1'b0, 1'b1));
  endtask

  // Halves built from the rule, first half random where the code allows
  task automatic biphase_case(input logic [1:0] code, input string name);
    bit b;
    bit h1;
    bit h2;
    tx_buf.delete();
    exp_q.delete();
    for (int i = 0; i < 24; i++) begin
      b  = rand_bit();
      h1 = rand_bit();
      if (code == pcm_code_pkg::code_m)
        h2 = h1 ^ b;
      else if (code == pcm_code_pkg::code_s)
        h2 = ~(h1 ^ b);
      else begin
        h1 = b;
        h2 = ~b;
      end
      tx_buf.push_back(h1);
      tx_buf.push_back(h2);
      exp_q.push_back(b);
    end
    run_and_check(name, cfg_word(code, 1'b1, pcm_code_pkg::derand_off, 1'b0, 1'b1));
  endtask

  task automatic derand_case(input logic [2:0] mode, input int ta, input int tb,
                             input string name);
    logic [pcm_code_pkg::hist_len-1:0] hist;
    bit                                d;
    bit                                s;
    tx_buf.delete();
    exp_q.delete();
    hist = '0;
    for (int i = 0; i < 40; i++) begin
      d = rand_bit();
      if (mode == pcm_code_pkg::derand_off)
        s = d;
      else
        s = d ^ hist[ta-1] ^ hist[tb-1];
      hist = {hist[pcm_code_pkg::hist_len-2:0], s};
      tx_buf.push_back(s);
      exp_q.push_back(d);
    end
    run_and_check(name, cfg_word(pcm_code_pkg::code_l, 1'b0, mode, 1'b0, 1'b1));
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_registers;
    int          e0;
    logic [31:0] exp;
    logic [31:0] got;
    logic [31:0] pat;
    e0  = errors;
    reset_dut;
    exp = '0;
    pat = 32'h5BA6_C33C;
    for (int i = 0; i < 4; i++) begin
      bus_write(1'b1, 4'b0001 << i, pcm_regs_pkg::addr_ctrl, pat);
      exp[8*i +: 8] = pat[8*i +: 8];
      bus_read(pcm_regs_pkg::addr_ctrl, got);
      check_val("rdata", got, exp);
    end
    check_val("fifo_rs", fifo_rs, exp[24]);
    check_val("clk_phase", clk_phase, exp[17:16]);
    // Neither of these may land
    bus_write(1'b0, 4'hf, pcm_regs_pkg::addr_ctrl, ~pat);
    bus_read(pcm_regs_pkg::addr_ctrl, got);
    check_val("rdata", got, exp);
    bus_write(1'b1, 4'hf, 13'h0004, ~pat);
    bus_read(pcm_regs_pkg::addr_ctrl, got);
    check_val("rdata", got, exp);
    bus_read(13'h0004, got);
    check_val("rdata", got, 32'h0);
    bus_write(1'b1, 4'hf, pcm_regs_pkg::addr_ctrl, 32'h0001_0000);
    bus_read(pcm_regs_pkg::addr_ctrl, got);
    check_val("fifo_rs", fifo_rs, 1'b0);
    check_val("clk_phase", clk_phase, 2'd1);
    $display("register test done, %0d errors", errors - e0);
  endtask

  task automatic test_nrz;
    int e0;
    e0 = errors;
    nrz_case(pcm_code_pkg::code_l, "nrz_l");
    check_val("clk_en_out delay", first_out - first_cyc, 3);
    nrz_case(pcm_code_pkg::code_m, "nrz_m");
    nrz_case(pcm_code_pkg::code_s, "nrz_s");
    $display("nrz test done, %0d errors", errors - e0);
  endtask

  task automatic test_biphase;
    int e0;
    e0 = errors;
    biphase_case(pcm_code_pkg::code_l, "biphase_l");
    biphase_case(pcm_code_pkg::code_m, "biphase_m");
    biphase_case(pcm_code_pkg::code_s, "biphase_s");
    $display("biphase test done, %0d errors", errors - e0);
  endtask

  task automatic test_derand;
    int e0;
    e0 = errors;
    derand_case(pcm_code_pkg::rnrz9, pcm_code_pkg::tap_rnrz9_a,
                pcm_code_pkg::tap_rnrz9_b, "rnrz9");
    derand_case(pcm_code_pkg::rnrz15, pcm_code_pkg::tap_rnrz15_a,
                pcm_code_pkg::tap_rnrz15_b, "rnrz15");
    derand_case(pcm_code_pkg::derand_off, 1, 1, "derand_off");
    $display("derandomizer test done, %0d errors", errors - e0);
  endtask

  task automatic test_format;
    int e0;
    bit s;
    e0 = errors;
    tx_buf.delete();
    exp_q.delete();
    for (int i = 0; i < 24; i++) begin
      s = rand_bit();
      tx_buf.push_back(s);
      exp_q.push_back(~s);
    end
    run_and_check("inverted", cfg_word(pcm_code_pkg::code_l, 1'b0,
                                       pcm_code_pkg::derand_off, 1'b1, 1'b1));
    // clk_sel clear after reset, both outputs follow the 2x strobe
    // Three clocks of delay line the 2x strobe up with bit 0 of ph
    reset_dut;
    repeat (8) @(posedge clk);
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      check_val("clk_en_out", clk_en_out, ph[0]);
      check_val("symb_clk", symb_clk, ph[0]);
    end
    $display("output format test done, %0d errors", errors - e0);
  endtask

  initial begin
    clk            = 1'b0;
    rs             = 1'b1;
    bus            = '0;
    symb_clk_en    = 1'b0;
    symb_clk_2x_en = 1'b0;
    symb           = 1'b0;
    ph             = 2'd0;
    from_q         = 1'b0;
    collect        = 1'b0;
    seed           = 77;
    errors         = 0;
    checks         = 0;
    cycle          = 0;
    first_cyc      = -1;
    first_out      = -1;
    clk_errs       = 0;
    reset_dut;
    test_registers;
    test_nrz;
    test_biphase;
    test_derand;
    test_format;
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
